/* logic/hb_bus_pkg.sv */
////////////////////////////////////////
// bus-side vector types for the timer window
// hart index allows up to 16 harts, the timer uses 8
////////////////////////////////////////

`default_nettype none

package hb_bus_pkg;

  // byte offset inside the timer window
  typedef logic [15:0] hb_addr_t;

  // write and read data of the high-speed bus
  typedef logic [31:0] hb_data_t;

  // hart number
  typedef logic [3:0] hart_idx_t;

endpackage

`default_nettype wire

/* logic/machine_timer.sv */
////////////////////////////////////////
// NUM_HARTS from 1 to 8, strobes need no handshake
// systemtimer_clk below half the hb_clk rate
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module machine_timer #(
  parameter int NUM_HARTS = 2
) (
  input  wire                       hb_clk,
  input  wire                       rst_n,
  input  wire                       systemtimer_clk,
  input  wire                       sel_ren,
  input  wire                       sel_wen,
  input  wire hb_bus_pkg::hb_addr_t raddr,
  input  wire hb_bus_pkg::hb_addr_t waddr,
  input  wire hb_bus_pkg::hb_data_t wdata,
  output hb_bus_pkg::hb_data_t      rdata,
  output logic [NUM_HARTS-1:0]      mtimer_int
);

  import hb_bus_pkg::*;
  import timer_pkg::*;

  logic                  tick_pulse;
  logic                  time_wr_lo;
  logic                  time_wr_hi;
  logic                  time_rd;
  logic [NUM_HARTS-1:0]  cmp_wr_lo;
  logic [NUM_HARTS-1:0]  cmp_wr_hi;
  logic                  rd_sel_time;
  logic                  rd_sel_hi;
  logic                  rd_valid;
  hart_idx_t             rd_hart;
  mtime_t                mtime;
  mtime_t [NUM_HARTS-1:0] cmp_bus;

  tick_sync u_tick_sync (
    .hb_clk          (hb_clk),
    .rst_n           (rst_n),
    .systemtimer_clk (systemtimer_clk),
    .tick_pulse      (tick_pulse)
  );

  timer_slave_decode #(
    .NUM_HARTS (NUM_HARTS)
  ) u_decode (
    .hb_clk      (hb_clk),
    .rst_n       (rst_n),
    .sel_ren     (sel_ren),
    .sel_wen     (sel_wen),
    .raddr       (raddr),
    .waddr       (waddr),
    .time_wr_lo  (time_wr_lo),
    .time_wr_hi  (time_wr_hi),
    .time_rd     (time_rd),
    .cmp_wr_lo   (cmp_wr_lo),
    .cmp_wr_hi   (cmp_wr_hi),
    .rd_sel_time (rd_sel_time),
    .rd_sel_hi   (rd_sel_hi),
    .rd_hart     (rd_hart),
    .rd_valid    (rd_valid)
  );

  mtime_counter u_mtime (
    .hb_clk     (hb_clk),
    .rst_n      (rst_n),
    .tick_pulse (tick_pulse),
    .time_wr_lo (time_wr_lo),
    .time_wr_hi (time_wr_hi),
    .time_rd    (time_rd),
    .wdata      (wdata),
    .mtime      (mtime)
  );

  // one compare unit per hart
  for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
    mtimecmp_unit u_cmp (
      .hb_clk     (hb_clk),
      .rst_n      (rst_n),
      .cmp_wr_lo  (cmp_wr_lo[h]),
      .cmp_wr_hi  (cmp_wr_hi[h]),
      .wdata      (wdata),
      .mtime      (mtime),
      .mtimecmp   (cmp_bus[h]),
      .mtimer_int (mtimer_int[h])
    );
  end

  timer_read_mux #(
    .NUM_HARTS (NUM_HARTS)
  ) u_read_mux (
    .hb_clk      (hb_clk),
    .rst_n       (rst_n),
    .rd_valid    (rd_valid),
    .rd_sel_time (rd_sel_time),
    .rd_sel_hi   (rd_sel_hi),
    .rd_hart     (rd_hart),
    .mtime       (mtime),
    .cmp_bus     (cmp_bus),
    .rdata       (rdata)
  );

endmodule

`default_nettype wire

/* logic/mtime_counter.sv */
////////////////////////////////////////
// up to 15 ticks may land on reads before the next tick
// a write to mtime drops a same-cycle tick
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mtime_counter (
  input  wire                    hb_clk,
  input  wire                    rst_n,
  input  wire                    tick_pulse,
  input  wire                    time_wr_lo,
  input  wire                    time_wr_hi,
  input  wire                    time_rd,
  input  wire hb_bus_pkg::hb_data_t wdata,
  output timer_pkg::mtime_t      mtime
);

  import timer_pkg::*;

  pend_cnt_t pend_cnt;
  mtime_t    next_mtime;
  logic      tick_on_read;

  // a tick adds itself plus whatever was held back
  assign next_mtime   = mtime + mtime_t'(pend_cnt) + mtime_t'(1);
  assign tick_on_read = tick_pulse && time_rd;

  always_ff @(posedge hb_clk or negedge rst_n) begin
    if (!rst_n) begin
      mtime    <= '0;
      pend_cnt <= '0;
    end else if (time_wr_lo || time_wr_hi) begin
      // software sets an absolute time, old ticks no longer apply
      if (time_wr_lo) begin
        mtime[31:0] <= wdata;
      end
      if (time_wr_hi) begin
        mtime[63:32] <= wdata;
      end
      pend_cnt <= '0;
    end else if (tick_on_read) begin
      // hold mtime steady for the read
      pend_cnt <= pend_cnt + 1'b1;
    end else if (tick_pulse) begin
      mtime    <= next_mtime;
      pend_cnt <= '0;
    end
  end

  a_pend_no_wrap : assert property (
    @(posedge hb_clk) disable iff (!rst_n)
      (pend_cnt == '1) |-> !(tick_on_read && !time_wr_lo && !time_wr_hi)
  );

endmodule

`default_nettype wire

/* logic/mtimecmp_unit.sv */
////////////////////////////////////////
// interrupt is a level, follows mtime one cycle late
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module mtimecmp_unit (
  input  wire                       hb_clk,
  input  wire                       rst_n,
  input  wire                       cmp_wr_lo,
  input  wire                       cmp_wr_hi,
  input  wire hb_bus_pkg::hb_data_t wdata,
  input  wire timer_pkg::mtime_t    mtime,
  output timer_pkg::mtime_t         mtimecmp,
  output logic                      mtimer_int
);

  import timer_pkg::*;

  logic cmp_wr;
  logic time_ge_cmp;

  assign cmp_wr      = cmp_wr_lo || cmp_wr_hi;
  assign time_ge_cmp = (mtime >= mtimecmp);

  always_ff @(posedge hb_clk or negedge rst_n) begin
    if (!rst_n) begin
      mtimecmp   <= CMP_RESET;
      mtimer_int <= 1'b0;
    end else begin
      if (cmp_wr_lo) begin
        mtimecmp[31:0] <= wdata;
      end
      if (cmp_wr_hi) begin
        mtimecmp[63:32] <= wdata;
      end
      // a new compare value acknowledges the interrupt
      if (cmp_wr) begin
        mtimer_int <= 1'b0;
      end else begin
        mtimer_int <= time_ge_cmp;
      end
    end
  end

  // both halves share wdata, one word targets one half
  a_one_half_per_write : assert property (
    @(posedge hb_clk) disable iff (!rst_n) !(cmp_wr_lo && cmp_wr_hi)
  );

endmodule

`default_nettype wire

/* logic/tick_sync.sv */
////////////////////////////////////////
// systemtimer_clk must run below half the hb_clk rate
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tick_sync (
  input  wire  hb_clk,
  input  wire  rst_n,
  input  wire  systemtimer_clk,
  output logic tick_pulse
);

  logic sync1;
  logic sync2;
  logic prev;

  // two stage synchronizer plus last sampled level
  always_ff @(posedge hb_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync1 <= 1'b0;
      sync2 <= 1'b0;
      prev  <= 1'b0;
    end else begin
      sync1 <= systemtimer_clk;
      sync2 <= sync1;
      prev  <= sync2;
    end
  end

  // one cycle per sampled rising edge
  assign tick_pulse = sync2 & ~prev;

endmodule

`default_nettype wire

/* logic/timer_pkg.sv */
////////////////////////////////////////
// timer types and register offset map
// hart h compare sits at CMP_BASE_OFS + 8*h, high half 4 above
////////////////////////////////////////

`default_nettype none

package timer_pkg;

  // full time or compare value
  typedef logic [63:0] mtime_t;

  // ticks that landed on an mtime read
  typedef logic [3:0] pend_cnt_t;

  // mtime halves
  localparam logic [15:0] MTIME_LO_OFS = 16'h0000;
  localparam logic [15:0] MTIME_HI_OFS = 16'h0004;

  // first compare register, one 8 byte slot per hart
  localparam logic [15:0] CMP_BASE_OFS = 16'h0008;

  // keeps every interrupt quiet until software sets a compare
  localparam mtime_t CMP_RESET = '1;

endpackage

`default_nettype wire

/* logic/timer_read_mux.sv */
////////////////////////////////////////
// rdata is zero on any cycle after no valid read
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module timer_read_mux #(
  parameter int NUM_HARTS = 2
) (
  input  wire                                    hb_clk,
  input  wire                                    rst_n,
  input  wire                                    rd_valid,
  input  wire                                    rd_sel_time,
  input  wire                                    rd_sel_hi,
  input  wire hb_bus_pkg::hart_idx_t             rd_hart,
  input  wire timer_pkg::mtime_t                 mtime,
  input  wire timer_pkg::mtime_t [NUM_HARTS-1:0] cmp_bus,
  output hb_bus_pkg::hb_data_t                   rdata
);

  import timer_pkg::*;

  mtime_t src;

  // pick the 64 bit source first
  always_comb begin
    src = '0;
    if (rd_sel_time) begin
      src = mtime;
    end else if (rd_hart < NUM_HARTS) begin
      src = cmp_bus[rd_hart];
    end
  end

  always_ff @(posedge hb_clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (!rd_valid) begin
      rdata <= '0;
    end else if (rd_sel_hi) begin
      rdata <= src[63:32];
    end else begin
      rdata <= src[31:0];
    end
  end

endmodule

`default_nettype wire

/* logic/timer_slave_decode.sv */
////////////////////////////////////////
// unaligned or out-of-window offsets give no strobe
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module timer_slave_decode #(
  parameter int NUM_HARTS = 2
) (
  input  wire                         hb_clk,
  input  wire                         rst_n,
  input  wire                         sel_ren,
  input  wire                         sel_wen,
  input  wire hb_bus_pkg::hb_addr_t   raddr,
  input  wire hb_bus_pkg::hb_addr_t   waddr,
  output logic                        time_wr_lo,
  output logic                        time_wr_hi,
  output logic                        time_rd,
  output logic [NUM_HARTS-1:0]        cmp_wr_lo,
  output logic [NUM_HARTS-1:0]        cmp_wr_hi,
  output logic                        rd_sel_time,
  output logic                        rd_sel_hi,
  output hb_bus_pkg::hart_idx_t       rd_hart,
  output logic                        rd_valid
);

  import hb_bus_pkg::*;
  import timer_pkg::*;

  // first offset past the last hart
  localparam hb_addr_t CMP_END_OFS = hb_addr_t'(CMP_BASE_OFS + 8 * NUM_HARTS);

  hb_addr_t w_rel;
  hb_addr_t r_rel;
  logic     w_cmp;
  logic     r_time;
  logic     r_cmp;

  // write side
  assign w_rel = waddr - CMP_BASE_OFS;
  assign w_cmp = (waddr[1:0] == 2'b00) && (waddr >= CMP_BASE_OFS) && (waddr < CMP_END_OFS);

  assign time_wr_lo = sel_wen && (waddr == MTIME_LO_OFS);
  assign time_wr_hi = sel_wen && (waddr == MTIME_HI_OFS);

  always_comb begin
    cmp_wr_lo = '0;
    cmp_wr_hi = '0;
    for (int h = 0; h < NUM_HARTS; h++) begin
      if (sel_wen && w_cmp && (w_rel[6:3] == hart_idx_t'(h))) begin
        cmp_wr_lo[h] = ~waddr[2];
        cmp_wr_hi[h] = waddr[2];
      end
    end
  end

  // read side, sampled by the read mux in the strobe cycle
  assign r_rel  = raddr - CMP_BASE_OFS;
  assign r_time = (raddr == MTIME_LO_OFS) || (raddr == MTIME_HI_OFS);
  assign r_cmp  = (raddr[1:0] == 2'b00) && (raddr >= CMP_BASE_OFS) && (raddr < CMP_END_OFS);

  assign time_rd     = sel_ren && r_time;
  assign rd_valid    = sel_ren && (r_time || r_cmp);
  assign rd_sel_time = r_time;
  assign rd_sel_hi   = raddr[2];
  assign rd_hart     = r_cmp ? r_rel[6:3] : '0;

  a_onehot_write : assert property (
    @(posedge hb_clk) disable iff (!rst_n)
      $onehot0({time_wr_lo, time_wr_hi, cmp_wr_lo, cmp_wr_hi})
  );

endmodule

`default_nettype wire

/* machine_timer.f */
logic/hb_bus_pkg.sv
logic/timer_pkg.sv
logic/tick_sync.sv
logic/timer_slave_decode.sv
logic/mtime_counter.sv
logic/mtimecmp_unit.sv
logic/timer_read_mux.sv
logic/machine_timer.sv
test/machine_timer_tb.sv

/* test/machine_timer_tb.sv */
////////////////////////////////////////
// two harts, tick clock period 140 ns
// ticks are gated off before every mtime read-back
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module machine_timer_tb;

  import hb_bus_pkg::*;
  import timer_pkg::*;

  localparam int   NUM_HARTS = 2;
  localparam logic OP_WRITE  = 1'b0;
  localparam logic OP_READ   = 1'b1;

  // one table row: operation, offset, write data, tick gate, expected read data
  typedef struct packed {
    logic     op;
    hb_addr_t ofs;
    hb_data_t data;
    logic     tick;
    hb_data_t expect_val;
  } step_t;

  logic                 hb_clk;
  logic                 rst_n;
  logic                 systemtimer_clk;
  logic                 sel_ren;
  logic                 sel_wen;
  hb_addr_t             raddr;
  hb_addr_t             waddr;
  hb_data_t             wdata;
  hb_data_t             rdata;
  logic [NUM_HARTS-1:0] mtimer_int;

  logic     tick_enable;
  int       tick_edges;
  int       cycles;
  step_t    steps[$];
  hb_data_t rnd[6];
  hb_data_t rnd_hi;
  mtime_t   exp_time;
  mtime_t   cmp_val;

  machine_timer #(
    .NUM_HARTS (NUM_HARTS)
  ) UUT (
    .hb_clk          (hb_clk),
    .rst_n           (rst_n),
    .systemtimer_clk (systemtimer_clk),
    .sel_ren         (sel_ren),
    .sel_wen         (sel_wen),
    .raddr           (raddr),
    .waddr           (waddr),
    .wdata           (wdata),
    .rdata           (rdata),
    .mtimer_int      (mtimer_int)
  );

  initial begin
    hb_clk = 1'b0;
    forever begin
      #10 hb_clk = ~hb_clk;
    end
  end

  // tick clock edges land at 5 mod 10 ns, clear of hb_clk edges
  initial begin
    systemtimer_clk = 1'b0;
    tick_edges = 0;
    #5;
    forever begin
      #70;
      if (systemtimer_clk) begin
        systemtimer_clk = 1'b0;
      end else if (tick_enable) begin
        systemtimer_clk = 1'b1;
        tick_edges++;
      end
    end
  end

  function automatic hb_addr_t cmp_ofs(input int hart, input logic hi);
    return hb_addr_t'(CMP_BASE_OFS + 8 * hart + (hi ? 4 : 0));
  endfunction

  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input string name, input hb_data_t expected,
                            input hb_data_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_irq(input logic [NUM_HARTS-1:0] expected);
    if (mtimer_int !== expected) begin
      $display("CHECK FAILED mtimer_int expected 0x%0h actual 0x%0h", expected, mtimer_int);
      stop_with_failure();
    end
  endtask

  task automatic write_word(input hb_addr_t ofs, input hb_data_t data);
    @(posedge hb_clk);
    sel_wen <= 1'b1;
    waddr   <= ofs;
    wdata   <= data;
    @(posedge hb_clk);
    sel_wen <= 1'b0;
  endtask

  // rdata is registered, so it is sampled half a cycle after the capturing edge
  task automatic read_word(input hb_addr_t ofs, output hb_data_t data);
    @(posedge hb_clk);
    sel_ren <= 1'b1;
    raddr   <= ofs;
    @(posedge hb_clk);
    sel_ren <= 1'b0;
    @(negedge hb_clk);
    data = rdata;
  endtask

  task automatic check_time(input mtime_t expected);
    hb_data_t lo;
    hb_data_t hi;
    mtime_t   actual;
    read_word(MTIME_LO_OFS, lo);
    read_word(MTIME_HI_OFS, hi);
    actual = {hi, lo};
    if (actual !== expected) begin
      $display("CHECK FAILED mtime expected 0x%016h actual 0x%016h", expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic add_step(input logic op, input hb_addr_t ofs, input hb_data_t data,
                          input logic tick, input hb_data_t expect_val);
    step_t s;
    s.op         = op;
    s.ofs        = ofs;
    s.data       = data;
    s.tick       = tick;
    s.expect_val = expect_val;
    steps.push_back(s);
  endtask

  task automatic run_steps();
    hb_data_t got;
    for (int i = 0; i < steps.size(); i++) begin
      tick_enable = steps[i].tick;
      if (steps[i].op == OP_WRITE) begin
        write_word(steps[i].ofs, steps[i].data);
      end else begin
        read_word(steps[i].ofs, got);
        check_data($sformatf("rdata at 0x%04h", steps[i].ofs), steps[i].expect_val, got);
      end
    end
    steps.delete();
  endtask

  task automatic wait_tick_edges(input int count);
    int target;
    int waited;
    target = tick_edges + count;
    waited = 0;
    while (tick_edges < target) begin
      @(posedge hb_clk);
      waited++;
      if (waited > 10 * count + 40) begin
        $display("tick clock produced too few edges within the wait limit");
        stop_with_failure();
      end
    end
  endtask

  // ticks need 2 to 3 cycles to reach mtime
  task automatic stop_ticks();
    tick_enable = 1'b0;
    repeat (10) @(posedge hb_clk);
  endtask

  initial begin
    void'($urandom(32'h9ad1));
    rst_n       = 1'b0;
    sel_ren     = 1'b0;
    sel_wen     = 1'b0;
    raddr       = '0;
    waddr       = '0;
    wdata       = '0;
    tick_enable = 1'b0;
    repeat (5) @(posedge hb_clk);
    rst_n <= 1'b1;
    @(negedge hb_clk);
    check_data("rdata", 32'h0, rdata);
    check_irq('0);

    // reset values, compares at all ones
    add_step(OP_READ, MTIME_LO_OFS, '0, 1'b0, 32'h0);
    add_step(OP_READ, MTIME_HI_OFS, '0, 1'b0, 32'h0);
    for (int h = 0; h < NUM_HARTS; h++) begin
      add_step(OP_READ, cmp_ofs(h, 1'b0), '0, 1'b0, 32'hFFFF_FFFF);
      add_step(OP_READ, cmp_ofs(h, 1'b1), '0, 1'b0, 32'hFFFF_FFFF);
    end
    run_steps();
    check_irq('0);

    // random write and read-back, offsets 0x0 to 0x14 cover mtime and both harts
    for (int i = 0; i < 6; i++) begin
      rnd[i] = $urandom();
      add_step(OP_WRITE, hb_addr_t'(4 * i), rnd[i], 1'b0, '0);
    end
    add_step(OP_WRITE, cmp_ofs(NUM_HARTS, 1'b0), $urandom(), 1'b0, '0);
    for (int i = 0; i < 6; i++) begin
      add_step(OP_READ, hb_addr_t'(4 * i), '0, 1'b0, rnd[i]);
    end
    add_step(OP_READ, cmp_ofs(NUM_HARTS, 1'b0), '0, 1'b0, 32'h0);
    add_step(OP_READ, 16'h0002, '0, 1'b0, 32'h0);
    add_step(OP_READ, 16'h000A, '0, 1'b0, 32'h0);
    add_step(OP_READ, 16'h0100, '0, 1'b0, 32'h0);
    run_steps();

    // carry from the low half into the high half
    rnd_hi = $urandom();
    add_step(OP_WRITE, MTIME_LO_OFS, 32'hFFFF_FFFE, 1'b0, '0);
    add_step(OP_WRITE, MTIME_HI_OFS, rnd_hi, 1'b0, '0);
    run_steps();
    tick_edges  = 0;
    tick_enable = 1'b1;
    wait_tick_edges(5);
    stop_ticks();
    exp_time = {rnd_hi, 32'hFFFF_FFFE} + mtime_t'(tick_edges);
    check_time(exp_time);

    // reads on every cycle, then one more tick to flush the pending count
    tick_edges  = 0;
    tick_enable = 1'b1;
    @(posedge hb_clk);
    sel_ren <= 1'b1;
    raddr   <= MTIME_LO_OFS;
    repeat (80) @(posedge hb_clk);
    sel_ren <= 1'b0;
    wait_tick_edges(1);
    stop_ticks();
    exp_time = exp_time + mtime_t'(tick_edges);
    check_time(exp_time);

    // hart 0 compare four ticks ahead, hart 1 parked at all ones
    cmp_val = exp_time + mtime_t'(4);
    add_step(OP_WRITE, cmp_ofs(1, 1'b1), 32'hFFFF_FFFF, 1'b0, '0);
    add_step(OP_WRITE, cmp_ofs(1, 1'b0), 32'hFFFF_FFFF, 1'b0, '0);
    add_step(OP_WRITE, cmp_ofs(0, 1'b1), cmp_val[63:32], 1'b0, '0);
    add_step(OP_WRITE, cmp_ofs(0, 1'b0), cmp_val[31:0], 1'b0, '0);
    run_steps();
    repeat (2) @(posedge hb_clk);
    @(negedge hb_clk);
    check_irq('0);

    tick_edges  = 0;
    tick_enable = 1'b1;
    cycles      = 0;
    while (mtimer_int[0] !== 1'b1) begin
      @(negedge hb_clk);
      if (mtimer_int[0] !== 1'b1) begin
        check_irq('0);
      end
      cycles++;
      if (cycles > 200) begin
        $display("hart 0 interrupt did not rise within 200 cycles");
        stop_with_failure();
      end
    end
    // the fourth tick settles well before the fifth edge arrives
    if (tick_edges != 4) begin
      $display("hart 0 interrupt did not rise on the tick that reached its compare value");
      stop_with_failure();
    end
    check_irq(2'b01);

    // low half first so the compare never dips below mtime
    cmp_val = exp_time + mtime_t'(32'h1000_0000);
    add_step(OP_WRITE, cmp_ofs(0, 1'b0), cmp_val[31:0], 1'b1, '0);
    add_step(OP_WRITE, cmp_ofs(0, 1'b1), cmp_val[63:32], 1'b1, '0);
    run_steps();
    cycles = 0;
    while (cycles < 40) begin
      @(negedge hb_clk);
      check_irq('0);
      cycles++;
    end
    stop_ticks();
    check_irq('0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire
